//--- rv_pkg.sv
package rv_pkg;

	// datapath width
	localparam int xlen = 64;

	// data memory depth in doublewords, and its index width
	localparam int dmem_words = 64;
	localparam int dmem_aw = $clog2(dmem_words);

	// major opcodes of the supported subset
	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		// lui passes the U immediate straight through
		alu_pass_b
	} alu_op_t;

	// everything the execute stage needs from decode
	typedef struct packed {
		logic [4:0] rs1_idx;
		logic [4:0] rs2_idx;
		logic [xlen-1:0] rs1_val;
		logic [xlen-1:0] rs2_val;
		logic [xlen-1:0] imm;
		logic [4:0] rd;
		alu_op_t alu_op;
		logic alu_src_imm;
		logic reg_write;
		logic mem_read;
		logic mem_write;
	} ex_payload_t;

	// ALU result plus what the memory and writeback need
	typedef struct packed {
		logic [xlen-1:0] result;
		logic [xlen-1:0] store_data;
		logic [4:0] rd;
		logic reg_write;
		logic mem_read;
		logic mem_write;
	} res_payload_t;

endpackage

//--- inst_fetch.sv
`timescale 1ns/1ps

module inst_fetch (
	input  logic clk,
	input  logic rst_n,
	input  logic inst_req,
	input  logic [31:0] inst,
	output logic inst_ack,
	output logic dec_valid,
	output logic [31:0] dec_inst
);

	typedef enum logic {
		st_idle,
		st_ack
	} state_t;

	state_t state;
	logic accept;

	// a new word is taken only from the idle state, so a held req is ignored
	assign accept = (state == st_idle) && inst_req;
	assign inst_ack = (state == st_ack);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= accept;
			case (state)
				st_idle: begin
					if (inst_req) begin
						state <= st_ack;
					end
				end
				st_ack: begin
					// wait for the source to drop req
					if (!inst_req) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			dec_inst <= inst;
		end
	end

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic [4:0] raddr1,
	input  logic [4:0] raddr2,
	input  logic we,
	input  logic [4:0] waddr,
	input  logic [xlen-1:0] wdata,
	output logic [xlen-1:0] rdata1,
	output logic [xlen-1:0] rdata2
);

	logic [xlen-1:0] regs [32];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	// write-through, so decode sees a value retiring in the same cycle
	assign rdata1 = (raddr1 == 5'd0) ? '0 :
		(we && waddr == raddr1) ? wdata : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? '0 :
		(we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

//--- pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  payload_t in_data,
	output logic out_valid,
	output payload_t out_data
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// payload only moves with a valid instruction
	always_ff @(posedge clk) begin
		if (in_valid) begin
			out_data <= in_data;
		end
	end

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage import rv_pkg::*; (
	input  logic dec_valid,
	input  logic [31:0] dec_inst,
	output logic [4:0] rf_raddr1,
	output logic [4:0] rf_raddr2,
	input  logic [xlen-1:0] rf_rdata1,
	input  logic [xlen-1:0] rf_rdata2,
	output logic ex_valid,
	output ex_payload_t ex_data
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic funct7_5;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;
	logic [xlen-1:0] imm_u;

	// funct3 to ALU op, shared by the register and immediate forms
	function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic alt,
		input logic is_reg);
		alu_op_t op;
		case (f3)
			3'b000: op = (alt && is_reg) ? alu_sub : alu_add;
			3'b001: op = alu_sll;
			3'b010: op = alu_slt;
			3'b011: op = alu_sltu;
			3'b100: op = alu_xor;
			3'b101: op = alt ? alu_sra : alu_srl;
			3'b110: op = alu_or;
			default: op = alu_and;
		endcase
		return op;
	endfunction

	assign opcode = dec_inst[6:0];
	assign rd = dec_inst[11:7];
	assign funct3 = dec_inst[14:12];
	assign rs1 = dec_inst[19:15];
	assign rs2 = dec_inst[24:20];
	assign funct7_5 = dec_inst[30];

	assign imm_i = {{(xlen-12){dec_inst[31]}}, dec_inst[31:20]};
	assign imm_s = {{(xlen-12){dec_inst[31]}}, dec_inst[31:25], dec_inst[11:7]};
	assign imm_u = {{(xlen-32){dec_inst[31]}}, dec_inst[31:12], 12'b0};

	assign rf_raddr1 = rs1;
	assign rf_raddr2 = rs2;
	assign ex_valid = dec_valid;

	always_comb begin
		// unknown encodings fall through with every control bit clear
		ex_data = '0;
		ex_data.rs1_idx = rs1;
		ex_data.rs2_idx = rs2;
		ex_data.rs1_val = rf_rdata1;
		ex_data.rs2_val = rf_rdata2;
		ex_data.rd = rd;
		ex_data.alu_op = alu_add;
		case (opcode)
			op_reg: begin
				ex_data.alu_op = alu_decode(funct3, funct7_5, 1'b1);
				ex_data.reg_write = 1'b1;
			end
			op_imm: begin
				ex_data.imm = imm_i;
				ex_data.alu_op = alu_decode(funct3, funct7_5, 1'b0);
				ex_data.alu_src_imm = 1'b1;
				ex_data.reg_write = 1'b1;
			end
			op_lui: begin
				ex_data.imm = imm_u;
				ex_data.alu_op = alu_pass_b;
				ex_data.alu_src_imm = 1'b1;
				ex_data.reg_write = 1'b1;
			end
			op_load: begin
				// only ld, narrower loads are treated as illegal
				if (funct3 == 3'b011) begin
					ex_data.imm = imm_i;
					ex_data.alu_src_imm = 1'b1;
					ex_data.reg_write = 1'b1;
					ex_data.mem_read = 1'b1;
				end
			end
			op_store: begin
				if (funct3 == 3'b011) begin
					ex_data.imm = imm_s;
					ex_data.alu_src_imm = 1'b1;
					ex_data.mem_write = 1'b1;
				end
			end
			default: ;
		endcase
	end

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
	input  logic ex_valid,
	input  ex_payload_t ex_data,
	input  logic fwd_valid,
	input  logic [4:0] fwd_rd,
	input  logic [xlen-1:0] fwd_data,
	output logic res_valid,
	output res_payload_t res_data
);

	logic fwd_a;
	logic fwd_b;
	logic [xlen-1:0] op_a;
	logic [xlen-1:0] rs2_val;
	logic [xlen-1:0] op_b;
	logic [5:0] shamt;
	logic [xlen-1:0] result;

	// take the retiring value when it targets one of our sources
	assign fwd_a = fwd_valid && (fwd_rd == ex_data.rs1_idx) && (ex_data.rs1_idx != 5'd0);
	assign fwd_b = fwd_valid && (fwd_rd == ex_data.rs2_idx) && (ex_data.rs2_idx != 5'd0);

	assign op_a = fwd_a ? fwd_data : ex_data.rs1_val;
	assign rs2_val = fwd_b ? fwd_data : ex_data.rs2_val;
	assign op_b = ex_data.alu_src_imm ? ex_data.imm : rs2_val;
	assign shamt = op_b[5:0];

	always_comb begin
		case (ex_data.alu_op)
			alu_add: result = op_a + op_b;
			alu_sub: result = op_a - op_b;
			alu_sll: result = op_a << shamt;
			alu_slt: result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			alu_sltu: result = {{(xlen-1){1'b0}}, op_a < op_b};
			alu_xor: result = op_a ^ op_b;
			alu_srl: result = op_a >> shamt;
			alu_sra: result = $signed(op_a) >>> shamt;
			alu_or: result = op_a | op_b;
			alu_and: result = op_a & op_b;
			alu_pass_b: result = op_b;
			default: result = '0;
		endcase
	end

	assign res_valid = ex_valid;

	always_comb begin
		res_data.result = result;
		// sd stores the forwarded rs2, the address comes from the adder
		res_data.store_data = rs2_val;
		res_data.rd = ex_data.rd;
		res_data.reg_write = ex_data.reg_write;
		res_data.mem_read = ex_data.mem_read;
		res_data.mem_write = ex_data.mem_write;
	end

endmodule

//--- result_stage.sv
`timescale 1ns/1ps

module result_stage import rv_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic res_valid,
	input  res_payload_t res_data,
	output logic rf_we,
	output logic [4:0] rf_waddr,
	output logic [xlen-1:0] rf_wdata,
	output logic fwd_valid,
	output logic [4:0] fwd_rd,
	output logic [xlen-1:0] fwd_data,
	output logic wb_valid,
	output logic wb_write,
	output logic [4:0] wb_rd,
	output logic [xlen-1:0] wb_data
);

	logic [xlen-1:0] dmem [dmem_words];
	logic [dmem_aw-1:0] maddr;
	logic [xlen-1:0] wb_value;

	// doubleword index, byte offset bits are dropped
	assign maddr = res_data.result[3 +: dmem_aw];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < dmem_words; i++) begin
				dmem[i] <= '0;
			end
		end else if (res_valid && res_data.mem_write) begin
			dmem[maddr] <= res_data.store_data;
		end
	end

	assign wb_value = res_data.mem_read ? dmem[maddr] : res_data.result;

	assign rf_we = res_valid && res_data.reg_write && (res_data.rd != 5'd0);
	assign rf_waddr = res_data.rd;
	assign rf_wdata = wb_value;

	// same value goes back into execute
	assign fwd_valid = rf_we;
	assign fwd_rd = res_data.rd;
	assign fwd_data = wb_value;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			wb_write <= 1'b0;
		end else begin
			wb_valid <= res_valid;
			wb_write <= rf_we;
		end
	end

	always_ff @(posedge clk) begin
		if (res_valid) begin
			wb_rd <= res_data.rd;
			wb_data <= rf_we ? wb_value : '0;
		end
	end

endmodule

//--- pipelined_datapath.sv
`timescale 1ns/1ps

module pipelined_datapath import rv_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic inst_req,
	input  logic [31:0] inst,
	output logic inst_ack,
	output logic wb_valid,
	output logic wb_write,
	output logic [4:0] wb_rd,
	output logic [63:0] wb_data
);

	logic dec_valid;
	logic [31:0] dec_inst;

	logic [4:0] rf_raddr1;
	logic [4:0] rf_raddr2;
	logic [xlen-1:0] rf_rdata1;
	logic [xlen-1:0] rf_rdata2;
	logic rf_we;
	logic [4:0] rf_waddr;
	logic [xlen-1:0] rf_wdata;

	// decode to execute
	logic id_valid;
	ex_payload_t id_data;
	logic ex_valid;
	ex_payload_t ex_data;

	// execute to result
	logic alu_valid;
	res_payload_t alu_data;
	logic res_valid;
	res_payload_t res_data;

	logic fwd_valid;
	logic [4:0] fwd_rd;
	logic [xlen-1:0] fwd_data;

	inst_fetch u_fetch (
		.clk(clk),
		.rst_n(rst_n),
		.inst_req(inst_req),
		.inst(inst),
		.inst_ack(inst_ack),
		.dec_valid(dec_valid),
		.dec_inst(dec_inst)
	);

	decode_stage u_decode (
		.dec_valid(dec_valid),
		.dec_inst(dec_inst),
		.rf_raddr1(rf_raddr1),
		.rf_raddr2(rf_raddr2),
		.rf_rdata1(rf_rdata1),
		.rf_rdata2(rf_rdata2),
		.ex_valid(id_valid),
		.ex_data(id_data)
	);

	reg_file u_rf (
		.clk(clk),
		.rst_n(rst_n),
		.raddr1(rf_raddr1),
		.raddr2(rf_raddr2),
		.we(rf_we),
		.waddr(rf_waddr),
		.wdata(rf_wdata),
		.rdata1(rf_rdata1),
		.rdata2(rf_rdata2)
	);

	pipe_reg #(.payload_t(ex_payload_t)) ex_reg (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(id_valid),
		.in_data(id_data),
		.out_valid(ex_valid),
		.out_data(ex_data)
	);

	execute_stage u_execute (
		.ex_valid(ex_valid),
		.ex_data(ex_data),
		.fwd_valid(fwd_valid),
		.fwd_rd(fwd_rd),
		.fwd_data(fwd_data),
		.res_valid(alu_valid),
		.res_data(alu_data)
	);

	pipe_reg #(.payload_t(res_payload_t)) res_reg (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(alu_valid),
		.in_data(alu_data),
		.out_valid(res_valid),
		.out_data(res_data)
	);

	result_stage u_result (
		.clk(clk),
		.rst_n(rst_n),
		.res_valid(res_valid),
		.res_data(res_data),
		.rf_we(rf_we),
		.rf_waddr(rf_waddr),
		.rf_wdata(rf_wdata),
		.fwd_valid(fwd_valid),
		.fwd_rd(fwd_rd),
		.fwd_data(fwd_data),
		.wb_valid(wb_valid),
		.wb_write(wb_write),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

endmodule

//--- pipelined_datapath_checker.sv
`timescale 1ns/1ps

module pipelined_datapath_checker (
	input  logic clk,
	input  logic rst_n,
	input  logic inst_req,
	input  logic inst_ack,
	input  logic wb_write,
	input  logic [4:0] wb_rd
);

	// number of assertion failures so far
	int failures = 0;

	// ack only answers a request seen at the previous edge
	ack_rise_with_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(inst_ack) |-> $past(inst_req))
		else begin
			failures++;
			$error("inst_ack rose without inst_req");
		end

	ack_holds_until_req_low: assert property (@(posedge clk) disable iff (!rst_n)
		(inst_ack && inst_req) |=> inst_ack)
		else begin
			failures++;
			$error("inst_ack fell while inst_req was still high");
		end

	write_not_x0: assert property (@(posedge clk) disable iff (!rst_n)
		wb_write |-> (wb_rd != 5'd0))
		else begin
			failures++;
			$error("wb_write set for x0");
		end

endmodule

bind pipelined_datapath pipelined_datapath_checker u_checker (
	.clk(clk),
	.rst_n(rst_n),
	.inst_req(inst_req),
	.inst_ack(inst_ack),
	.wb_write(wb_write),
	.wb_rd(wb_rd)
);

//--- tb_pipelined_datapath.sv
`timescale 1ns/1ps

module tb_pipelined_datapath import rv_pkg::*; ();

	localparam int wait_limit = 50;

	logic clk;
	logic rst_n;
	logic inst_req;
	logic [31:0] inst;
	logic inst_ack;
	logic wb_valid;
	logic wb_write;
	logic [4:0] wb_rd;
	logic [63:0] wb_data;

	int errors;
	int checks;
	int cyc = 0;
	logic [31:0] rng_state;

	// architectural state of the reference model
	logic [63:0] sh_regs [32];
	logic [63:0] sh_mem [dmem_words];

	// program to send and the retires it should produce
	logic [31:0] prog [$];
	logic exp_write [$];
	logic [4:0] exp_rd [$];
	logic [63:0] exp_data [$];
	int acc_cycle [$];

	pipelined_datapath dut (
		.clk(clk),
		.rst_n(rst_n),
		.inst_req(inst_req),
		.inst(inst),
		.inst_ack(inst_ack),
		.wb_valid(wb_valid),
		.wb_write(wb_write),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic logic [63:0] rand64();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = next_rand();
		lo = next_rand();
		return {hi, lo};
	endfunction

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], op_store};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, op_lui};
	endfunction

	// op is {funct7 bit 5, funct3}
	function automatic logic [63:0] alu_ref(input logic [3:0] op, input logic [63:0] a,
		input logic [63:0] b);
		case (op)
			4'b0000: return a + b;
			4'b1000: return a - b;
			4'b0001: return a << b[5:0];
			4'b0010: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
			4'b0011: return (a < b) ? 64'd1 : 64'd0;
			4'b0100: return a ^ b;
			4'b0101: return a >> b[5:0];
			4'b1101: return $signed(a) >>> b[5:0];
			4'b0110: return a | b;
			4'b0111: return a & b;
			default: return 64'd0;
		endcase
	endfunction

	function automatic int mem_index(input logic [63:0] addr);
		return int'((addr >> 3) % dmem_words);
	endfunction

	// executes one instruction on the shadow state
	task automatic predict(input logic [31:0] w, output logic write, output logic [63:0] value);
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] imm_i;
		logic [63:0] imm_s;
		logic alt;
		a = sh_regs[w[19:15]];
		b = sh_regs[w[24:20]];
		imm_i = {{52{w[31]}}, w[31:20]};
		imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
		// immediate forms only use bit 30 to pick srai
		alt = (w[14:12] == 3'b101) ? w[30] : 1'b0;
		write = 1'b1;
		value = 64'd0;
		case (w[6:0])
			op_reg: value = alu_ref({w[30], w[14:12]}, a, b);
			op_imm: value = alu_ref({alt, w[14:12]}, a, imm_i);
			op_lui: value = {{32{w[31]}}, w[31:12], 12'h000};
			op_load: begin
				if (w[14:12] == 3'b011) begin
					value = sh_mem[mem_index(a + imm_i)];
				end else begin
					write = 1'b0;
				end
			end
			op_store: begin
				write = 1'b0;
				if (w[14:12] == 3'b011) begin
					sh_mem[mem_index(a + imm_s)] = b;
				end
			end
			default: write = 1'b0;
		endcase
		if (w[11:7] == 5'd0) begin
			write = 1'b0;
		end
		if (write) begin
			sh_regs[w[11:7]] = value;
		end else begin
			value = 64'd0;
		end
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED at %0t: %s = %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// one full four-phase cycle, entered and left on a falling edge
	task automatic send_inst(input logic [31:0] word);
		int n;
		inst = word;
		inst_req = 1'b1;
		n = 0;
		while (!inst_ack && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (!inst_ack) begin
			errors++;
			$display("inst_ack never rose for instruction %h", word);
		end
		acc_cycle.push_back(cyc);
		inst_req = 1'b0;
		n = 0;
		while (inst_ack && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (inst_ack) begin
			errors++;
			$display("inst_ack stayed high after inst_req was dropped");
		end
	endtask

	task automatic send_all();
		logic write;
		logic [63:0] value;
		foreach (prog[i]) begin
			predict(prog[i], write, value);
			exp_write.push_back(write);
			exp_rd.push_back(prog[i][11:7]);
			exp_data.push_back(value);
			send_inst(prog[i]);
		end
	endtask

	task automatic collect_retire();
		int n;
		n = 0;
		while (!wb_valid && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (!wb_valid || exp_write.size() == 0) begin
			errors++;
			$display("expected retire did not arrive within %0d cycles", wait_limit);
		end else begin
			check_value("wb_write", wb_write, exp_write[0]);
			check_value("wb_rd", wb_rd, exp_rd[0]);
			check_value("wb_data", wb_data, exp_data[0]);
			check_value("retire latency", cyc - acc_cycle[0], 3);
			@(negedge clk);
			// a retire is a single-cycle pulse
			check_value("wb_valid after retire", wb_valid, 0);
			void'(exp_write.pop_front());
			void'(exp_rd.pop_front());
			void'(exp_data.pop_front());
			void'(acc_cycle.pop_front());
		end
	endtask

	// sender and collector run side by side so instructions overlap
	task automatic run_program();
		int count;
		count = prog.size();
		fork
			send_all();
			repeat (count) collect_retire();
		join
		prog.delete();
	endtask

	// addi, then five rounds of slli 11 and ori with 11 bits
	task automatic load_reg(input logic [4:0] rd, input logic [63:0] v);
		prog.push_back(i_type({3'b000, v[63:55]}, 5'd0, 3'b000, rd, op_imm));
		for (int k = 4; k >= 0; k--) begin
			prog.push_back(i_type(12'd11, rd, 3'b001, rd, op_imm));
			prog.push_back(i_type({1'b0, v[k*11 +: 11]}, rd, 3'b110, rd, op_imm));
		end
	endtask

	task automatic handshake_and_reset();
		check_value("inst_ack after reset", inst_ack, 0);
		check_value("wb_valid after reset", wb_valid, 0);
		prog.push_back(i_type(12'd7, 5'd0, 3'b000, 5'd1, op_imm));
		prog.push_back(i_type(12'hfff, 5'd1, 3'b000, 5'd2, op_imm));
		prog.push_back(u_type(20'h80001, 5'd3));
		run_program();
	endtask

	task automatic imm_ops();
		logic [31:0] r;
		logic [2:0] f3;
		logic [11:0] imm;
		load_reg(5'd8, rand64());
		load_reg(5'd9, rand64());
		for (int i = 0; i < 24; i++) begin
			r = next_rand();
			f3 = r[2:0];
			imm = r[31:20];
			// shifts carry a 6-bit amount and bit 30 picks srai
			if (f3 == 3'b001) begin
				imm = {6'b000000, r[25:20]};
			end else if (f3 == 3'b101) begin
				imm = {1'b0, r[19], 4'b0000, r[25:20]};
			end
			prog.push_back(i_type(imm, {4'b0100, r[8]}, f3, r[13:9], op_imm));
			if (i % 6 == 5) begin
				r = next_rand();
				prog.push_back(u_type(r[31:12], r[11:7]));
			end
		end
		run_program();
	endtask

	task automatic reg_ops();
		logic [63:0] v;
		for (int round = 0; round < 3; round++) begin
			v = rand64();
			// one round with a negative first operand for the compares
			if (round == 1) begin
				v[63] = 1'b1;
			end
			load_reg(5'd5, v);
			load_reg(5'd6, rand64());
			for (int k = 0; k < 8; k++) begin
				prog.push_back(r_type(7'b0000000, 5'd6, 5'd5, 3'(k), 5'(16 + k)));
			end
			prog.push_back(r_type(7'b0100000, 5'd6, 5'd5, 3'b000, 5'd24));
			prog.push_back(r_type(7'b0100000, 5'd6, 5'd5, 3'b101, 5'd25));
			prog.push_back(r_type(7'b0000000, 5'd5, 5'd6, 3'b010, 5'd26));
			prog.push_back(r_type(7'b0000000, 5'd5, 5'd6, 3'b011, 5'd27));
			run_program();
		end
	endtask

	task automatic dependent_chain();
		logic [31:0] r;
		logic [6:0] f7;
		load_reg(5'd10, rand64());
		prog.push_back(r_type(7'b0000000, 5'd10, 5'd10, 3'b000, 5'd11));
		prog.push_back(r_type(7'b0100000, 5'd10, 5'd11, 3'b000, 5'd12));
		prog.push_back(r_type(7'b0000000, 5'd12, 5'd11, 3'b100, 5'd13));
		prog.push_back(i_type(12'h7ff, 5'd13, 3'b000, 5'd13, op_imm));
		prog.push_back(r_type(7'b0000000, 5'd13, 5'd13, 3'b111, 5'd14));
		prog.push_back(r_type(7'b0100000, 5'd11, 5'd14, 3'b101, 5'd15));
		for (int i = 0; i < 10; i++) begin
			r = next_rand();
			f7 = ((r[2:0] == 3'b000 || r[2:0] == 3'b101) && r[3]) ? 7'b0100000 : 7'b0000000;
			prog.push_back(r_type(f7, {2'b01, r[9:7]}, {2'b01, r[6:4]}, r[2:0],
				{2'b01, r[12:10]}));
		end
		run_program();
	endtask

	task automatic store_then_load();
		logic [11:0] off [4];
		logic [4:0] base;
		logic [31:0] r;
		for (int k = 0; k < 4; k++) begin
			load_reg(5'(20 + k), rand64());
		end
		load_reg(5'd7, 64'd64);
		for (int k = 0; k < 4; k++) begin
			r = next_rand();
			off[k] = {3'b000, r[5:0], 3'b000};
			base = (k == 3) ? 5'd7 : 5'd0;
			prog.push_back(s_type(off[k], 5'(20 + k), base));
		end
		for (int k = 0; k < 4; k++) begin
			base = (k == 3) ? 5'd7 : 5'd0;
			prog.push_back(i_type(off[k], base, 3'b011, 5'(24 + k), op_load));
		end
		run_program();
	endtask

	task automatic x0_and_illegal();
		load_reg(5'd3, rand64());
		prog.push_back(i_type(12'd123, 5'd0, 3'b000, 5'd0, op_imm));
		prog.push_back(u_type(20'habcde, 5'd0));
		prog.push_back(r_type(7'b0000000, 5'd0, 5'd0, 3'b000, 5'd1));
		// unknown opcode and a byte load both aimed at x3
		prog.push_back({20'h12345, 5'd3, 7'b1111111});
		prog.push_back(i_type(12'd0, 5'd0, 3'b000, 5'd3, op_load));
		prog.push_back(i_type(12'd0, 5'd3, 3'b000, 5'd4, op_imm));
		prog.push_back(r_type(7'b0000000, 5'd0, 5'd3, 3'b110, 5'd5));
		run_program();
	endtask

	initial begin
		rst_n = 1'b0;
		inst_req = 1'b0;
		inst = 32'd0;
		rng_state = 32'h31e8_3e40;
		errors = 0;
		checks = 0;
		for (int i = 0; i < 32; i++) begin
			sh_regs[i] = 64'd0;
		end
		for (int i = 0; i < dmem_words; i++) begin
			sh_mem[i] = 64'd0;
		end
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		handshake_and_reset();
		imm_ops();
		reg_ops();
		dependent_chain();
		store_then_load();
		x0_and_illegal();
		$display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			dut.u_checker.failures);
		if (errors == 0 && dut.u_checker.failures == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- all.f
rv_pkg.sv
inst_fetch.sv
reg_file.sv
pipe_reg.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
pipelined_datapath.sv
pipelined_datapath_checker.sv
tb_pipelined_datapath.sv

//--- Bender.yml
package:
  name: pipelined_datapath

sources:
  - rv_pkg.sv
  - inst_fetch.sv
  - reg_file.sv
  - pipe_reg.sv
  - decode_stage.sv
  - execute_stage.sv
  - result_stage.sv
  - pipelined_datapath.sv
  - target: test
    files:
      - pipelined_datapath_checker.sv
      - tb_pipelined_datapath.sv
